// ==== axi_read_master.sv ====
module axi_read_master (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [isp_pkg::addr_w-1:0]  pic_addr,
    input  logic                        arready,
    input  logic [isp_pkg::data_w-1:0]  rdata,
    input  logic                        rlast,
    input  logic                        rvalid,
    input  logic                        beat_ready,
    output logic [isp_pkg::addr_w-1:0]  araddr,
    output logic [7:0]                  arlen,
    output logic                        arvalid,
    output logic                        rready,
    output logic                        beat_valid,
    output logic [isp_pkg::data_w-1:0]  beat_data,
    output logic [1:0]                  beat_plane,
    output logic                        beat_last
);
    import isp_pkg::*;

    localparam int cnt_w = $clog2(burst_beats);

    logic             burst_open;
    logic [cnt_w-1:0] beat_cnt;
    logic             ar_hs;
    logic             r_hs;

    assign arlen = 8'(burst_beats - 1);
    assign ar_hs = arvalid & arready;

    // data phase follows the write side's back-pressure
    assign rready = burst_open & beat_ready;
    assign r_hs   = rvalid & rready;

    assign beat_valid = rvalid & burst_open;
    assign beat_data  = rdata;
    assign beat_last  = rlast;
    assign beat_plane = 2'(beat_cnt / plane_beats);

    always_ff @(posedge clk) begin
        if (start) begin
            araddr <= pic_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arvalid <= 1'b0;
        end else if (start) begin
            arvalid <= 1'b1;
        end else if (ar_hs) begin
            arvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_open <= 1'b0;
        end else if (ar_hs) begin
            burst_open <= 1'b1;
        end else if (r_hs && rlast) begin
            burst_open <= 1'b0;
        end
    end

    // beat index within the picture, plane boundary every 64 beats
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (start) begin
            beat_cnt <= '0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

// ==== axi_write_back.sv ====
module axi_write_back (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic [isp_pkg::addr_w-1:0]  pic_addr,
    input  isp_pkg::ratio_t             ratio,
    input  logic                        beat_valid,
    input  logic [isp_pkg::data_w-1:0]  beat_data,
    input  logic                        beat_last,
    input  logic                        awready,
    input  logic                        wready,
    input  logic                        bvalid,
    output logic                        beat_ready,
    output logic [isp_pkg::addr_w-1:0]  awaddr,
    output logic [7:0]                  awlen,
    output logic                        awvalid,
    output logic [isp_pkg::data_w-1:0]  wdata,
    output logic                        wlast,
    output logic                        wvalid,
    output logic                        wr_done
);
    import isp_pkg::*;

    logic              bready;
    logic              aw_hs;
    logic              w_hs;
    logic              beat_hs;
    logic [data_w-1:0] scaled;

    assign bready  = 1'b1;
    assign awlen   = 8'(burst_beats - 1);
    assign aw_hs   = awvalid & awready;
    assign w_hs    = wvalid & wready;

    // one-beat holding register, address goes out before any data
    assign beat_ready = ~wvalid & ~awvalid;
    assign beat_hs    = beat_valid & beat_ready;

    always_comb begin
        for (int i = 0; i < beat_bytes; i++) begin
            scaled[i*8 +: 8] = scale_byte(beat_data[i*8 +: 8], ratio);
        end
    end

    // ========================================
    // write address
    // ========================================
    always_ff @(posedge clk) begin
        if (start) begin
            awaddr <= pic_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awvalid <= 1'b0;
        end else if (start) begin
            awvalid <= 1'b1;
        end else if (aw_hs) begin
            awvalid <= 1'b0;
        end
    end

    // ========================================
    // write data and response
    // ========================================
    always_ff @(posedge clk) begin
        if (beat_hs) begin
            wdata <= scaled;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
        end else if (beat_hs) begin
            wvalid <= 1'b1;
            wlast  <= beat_last;
        end else if (w_hs) begin
            wvalid <= 1'b0;
            wlast  <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_done <= 1'b0;
        end else begin
            wr_done <= bvalid & bready;
        end
    end

endmodule

// ==== build.f ====
isp_pkg.sv
isp_ctrl.sv
axi_read_master.sv
axi_write_back.sv
exposure_accum.sv
isp_top.sv
dram_model.sv
isp_checker.sv
tb_isp.sv

// ==== dram_model.sv ====
module dram_model (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [isp_pkg::addr_w-1:0]  araddr,
    input  logic [7:0]                  arlen,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [isp_pkg::data_w-1:0]  rdata,
    output logic                        rlast,
    output logic                        rvalid,
    input  logic                        rready,
    input  logic [isp_pkg::addr_w-1:0]  awaddr,
    input  logic [7:0]                  awlen,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [isp_pkg::data_w-1:0]  wdata,
    input  logic                        wlast,
    input  logic                        wvalid,
    output logic                        wready,
    output logic                        bvalid
);
    import isp_pkg::*;

    localparam int          mem_words    = pic_count * burst_beats;
    localparam int          bright_first = 12;
    localparam logic [31:0] seed         = 32'd43224;

    logic [data_w-1:0] mem [mem_words];
    logic [31:0]       stall_rnd;
    logic [11:0]       rd_idx;
    logic [8:0]        rd_left;
    logic [11:0]       wr_idx;
    logic [8:0]        wr_left;
    logic              ar_hs;
    logic              aw_hs;

    assign ar_hs = arvalid & arready;
    assign aw_hs = awvalid & awready;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [11:0] word_index(input logic [31:0] a);
        return 12'((a - dram_base) >> 4);
    endfunction

    // upper pictures are bright, every byte has its top bit set
    initial begin
        logic [31:0]       rnd;
        logic [data_w-1:0] word;
        rnd = seed;
        for (int w = 0; w < mem_words; w++) begin
            for (int j = 0; j < data_w / 32; j++) begin
                rnd = xorshift(rnd);
                word[j*32 +: 32] = rnd;
            end
            if (w / burst_beats >= bright_first) begin
                word = word | {beat_bytes{8'h80}};
            end
            mem[w] <= word;
        end
        stall_rnd <= rnd;
        arready   <= 1'b0;
        rdata     <= '0;
        rlast     <= 1'b0;
        rvalid    <= 1'b0;
        awready   <= 1'b0;
        wready    <= 1'b0;
        bvalid    <= 1'b0;
        rd_idx    <= '0;
        rd_left   <= '0;
        wr_idx    <= '0;
        wr_left   <= '0;
    end

    always @(posedge clk) begin
        stall_rnd <= xorshift(stall_rnd);
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            rd_left <= '0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            wr_left <= '0;
        end else begin
            // ========================================
            // read side, one burst at a time
            // ========================================
            if (ar_hs) begin
                rd_idx  <= word_index(araddr);
                rd_left <= {1'b0, arlen} + 9'd1;
            end
            arready <= (rd_left == 9'd0) && !rvalid && !ar_hs && stall_rnd[0];
            if ((!rvalid || rready) && rd_left != 9'd0 && stall_rnd[2:1] != 2'b00) begin
                rvalid  <= 1'b1;
                rdata   <= mem[rd_idx];
                rlast   <= (rd_left == 9'd1);
                rd_idx  <= rd_idx + 12'd1;
                rd_left <= rd_left - 9'd1;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
                rlast  <= 1'b0;
            end

            // ========================================
            // write side
            // ========================================
            if (aw_hs) begin
                wr_idx  <= word_index(awaddr);
                wr_left <= {1'b0, awlen} + 9'd1;
            end
            awready <= (wr_left == 9'd0) && !aw_hs && stall_rnd[3];
            wready  <= (wr_left != 9'd0) && stall_rnd[5:4] != 2'b00;
            bvalid  <= 1'b0;
            if (wvalid && wready && wr_left != 9'd0) begin
                mem[wr_idx] <= wdata;
                wr_idx      <= wr_idx + 12'd1;
                wr_left     <= wr_left - 9'd1;
                bvalid      <= wlast;
            end
        end
    end

endmodule

// ==== exposure_accum.sv ====
module exposure_accum (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        clear,
    input  isp_pkg::ratio_t             ratio,
    input  logic                        beat_valid,
    input  logic                        beat_ready,
    input  logic [isp_pkg::data_w-1:0]  beat_data,
    input  logic [1:0]                  beat_plane,
    input  logic                        beat_last,
    output logic                        sum_done,
    output logic [isp_pkg::sum_w-1:0]   sum
);
    import isp_pkg::*;

    logic                beat_hs;
    logic [6:0]          gray [beat_bytes];
    logic [7:0]          add1 [8];
    logic [8:0]          add2 [4];
    logic [9:0]          add3 [2];
    logic [10:0]         add4;
    logic [tree_depth:0] tag_v;
    logic [tree_depth:0] tag_l;

    // G weighs one half, R and B one quarter
    function automatic logic [6:0] gray_weight(input logic [7:0] b, input logic [1:0] plane);
        logic [7:0] w;
        w = (plane == 2'd1) ? (b >> 1) : (b >> 2);
        return w[6:0];
    endfunction

    assign beat_hs = beat_valid & beat_ready;

    // ========================================
    // weighting and adder tree
    // ========================================
    always_ff @(posedge clk) begin
        for (int i = 0; i < beat_bytes; i++) begin
            gray[i] <= gray_weight(scale_byte(beat_data[i*8 +: 8], ratio), beat_plane);
        end
        for (int i = 0; i < 8; i++) begin
            add1[i] <= {1'b0, gray[2*i]} + {1'b0, gray[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            add2[i] <= {1'b0, add1[2*i]} + {1'b0, add1[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            add3[i] <= {1'b0, add2[2*i]} + {1'b0, add2[2*i+1]};
        end
        add4 <= {1'b0, add3[0]} + {1'b0, add3[1]};
    end

    // tags ride alongside the tree stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tag_v <= '0;
            tag_l <= '0;
        end else begin
            tag_v <= {tag_v[tree_depth-1:0], beat_hs};
            tag_l <= {tag_l[tree_depth-1:0], beat_hs & beat_last};
        end
    end

    // ========================================
    // running sum
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum      <= '0;
            sum_done <= 1'b0;
        end else if (clear) begin
            sum      <= '0;
            sum_done <= 1'b0;
        end else begin
            if (tag_v[tree_depth]) begin
                sum <= sum + sum_w'(add4);
            end
            sum_done <= tag_v[tree_depth] & tag_l[tree_depth];
        end
    end

endmodule

// ==== isp_checker.sv ====
module isp_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [isp_pkg::pic_w-1:0]   in_pic_no,
    input  logic [1:0]                  in_ratio_mode,
    input  logic                        exp_hit,
    input  logic                        out_valid,
    input  logic [7:0]                  out_data,
    input  logic [isp_pkg::addr_w-1:0]  araddr,
    input  logic [7:0]                  arlen,
    input  logic                        arvalid,
    input  logic                        arready,
    input  logic [isp_pkg::data_w-1:0]  rdata,
    input  logic                        rvalid,
    input  logic                        rready,
    input  logic [isp_pkg::addr_w-1:0]  awaddr,
    input  logic [7:0]                  awlen,
    input  logic                        awvalid,
    input  logic                        awready,
    input  logic [isp_pkg::data_w-1:0]  wdata,
    input  logic                        wlast,
    input  logic                        wvalid,
    input  logic                        wready,
    output int                          errors
);
    import isp_pkg::*;

    int                cycle;
    int                req_cycle;
    int                rd_n;
    int                wr_n;
    int                gray_sum;
    logic [pic_w-1:0]  req_pic;
    logic [1:0]        req_ratio;
    logic              pred_hit;
    logic              arvalid_seen;
    logic              reset_check;
    logic [data_w-1:0] exp_beats [$];
    logic              rec_valid [pic_count];
    logic [7:0]        rec_val [pic_count];

    function automatic logic [7:0] scale_by_ratio(input logic [7:0] b, input logic [1:0] mode);
        case (mode)
            2'd0:    return b >> 2;
            2'd1:    return b >> 1;
            2'd2:    return b;
            default: return (b > 8'd127) ? 8'd255 : 8'(b * 2);
        endcase
    endfunction

    function automatic logic [31:0] picture_address(input logic [pic_w-1:0] p);
        return dram_base + 32'(p) * 32'(pic_bytes);
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("FAILED at %0t: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        logic [data_w-1:0] scaled;
        logic [data_w-1:0] exp_w;
        logic [7:0]        s;
        logic [7:0]        exp_out;
        int                plane;
        if (!rst_n) begin
            errors       = 0;
            cycle        = 0;
            req_cycle    = 0;
            pred_hit     = 1'b0;
            arvalid_seen = 1'b1;
            reset_check  = 1'b1;
            exp_beats.delete();
            for (int i = 0; i < pic_count; i++) begin
                rec_valid[i] = 1'b0;
            end
        end else begin
            cycle++;
            if (reset_check) begin
                if (out_valid || arvalid || awvalid || wvalid || rready) begin
                    flag_error("valid or ready outputs not low after reset");
                end
                reset_check = 1'b0;
            end

            // ========================================
            // new request and cache prediction
            // ========================================
            if (in_valid) begin
                req_pic      = in_pic_no;
                req_ratio    = in_ratio_mode;
                req_cycle    = cycle;
                pred_hit     = rec_valid[in_pic_no] && in_ratio_mode == 2'd2;
                arvalid_seen = 1'b0;
                rd_n         = 0;
                wr_n         = 0;
                gray_sum     = 0;
                exp_beats.delete();
                if (pred_hit != exp_hit) begin
                    flag_error($sformatf("picture %0d, table hit %0d but predicted %0d",
                                         in_pic_no, exp_hit, pred_hit));
                end
            end
            if (arvalid && !arvalid_seen) begin
                arvalid_seen = 1'b1;
                if (cycle - req_cycle != 2) begin
                    flag_error($sformatf("arvalid rose %0d cycles after request",
                                         cycle - req_cycle));
                end
            end
            if (arvalid && arready) begin
                if (pred_hit) begin
                    flag_error("read address handshake on a cache hit");
                end
                if (araddr != picture_address(req_pic) || arlen != 8'(burst_beats - 1)) begin
                    flag_error($sformatf("read burst addr %h len %0d", araddr, arlen));
                end
            end
            if (awvalid && awready) begin
                if (pred_hit) begin
                    flag_error("write address handshake on a cache hit");
                end
                if (awaddr != picture_address(req_pic) || awlen != 8'(burst_beats - 1)) begin
                    flag_error($sformatf("write burst addr %h len %0d", awaddr, awlen));
                end
            end

            // ========================================
            // beat prediction
            // ========================================
            if (rvalid && rready) begin
                plane = rd_n / plane_beats;
                for (int i = 0; i < beat_bytes; i++) begin
                    s = scale_by_ratio(rdata[i*8 +: 8], req_ratio);
                    scaled[i*8 +: 8] = s;
                    gray_sum += (plane == 1) ? int'(s >> 1) : int'(s >> 2);
                end
                exp_beats.push_back(scaled);
                rd_n++;
            end
            if (wvalid && wready) begin
                if (exp_beats.size() == 0) begin
                    flag_error("write beat with no read beat before it");
                end else begin
                    exp_w = exp_beats.pop_front();
                    if (wdata !== exp_w) begin
                        flag_error($sformatf("write beat %0d is %h, expected %h",
                                             wr_n, wdata, exp_w));
                    end
                end
                wr_n++;
                if (wlast !== (wr_n == burst_beats)) begin
                    flag_error($sformatf("wlast %b on write beat %0d", wlast, wr_n - 1));
                end
            end

            // ========================================
            // result
            // ========================================
            if (out_valid) begin
                if (pred_hit) begin
                    exp_out = rec_val[req_pic];
                    if (cycle - req_cycle != 2) begin
                        flag_error($sformatf("cache hit result after %0d cycles",
                                             cycle - req_cycle));
                    end
                end else begin
                    exp_out = 8'(gray_sum >> result_shift);
                    if (rd_n != burst_beats || wr_n != burst_beats) begin
                        flag_error($sformatf("%0d read and %0d write beats", rd_n, wr_n));
                    end
                    rec_valid[req_pic] = 1'b1;
                    rec_val[req_pic]   = exp_out;
                end
                if (out_data !== exp_out) begin
                    flag_error($sformatf("picture %0d ratio %0d gave %0d, expected %0d",
                                         req_pic, req_ratio, out_data, exp_out));
                end
            end
        end
    end

endmodule

// ==== isp_ctrl.sv ====
module isp_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        in_valid,
    input  logic [isp_pkg::pic_w-1:0]   in_pic_no,
    input  logic [1:0]                  in_ratio_mode,
    input  logic                        wr_done,
    input  logic                        sum_done,
    input  logic [isp_pkg::sum_w-1:0]   sum,
    output logic                        start,
    output logic                        clear,
    output logic [isp_pkg::addr_w-1:0]  pic_addr,
    output isp_pkg::ratio_t             ratio,
    output logic                        out_valid,
    output logic [7:0]                  out_data
);
    import isp_pkg::*;

    isp_state_t           state;
    isp_state_t           state_nxt;
    logic [pic_w-1:0]     pic_q;
    logic [pic_count-1:0] rec_valid;
    logic [7:0]           rec_data [pic_count];
    logic                 hit;
    logic                 wr_seen;
    logic                 sum_seen;
    logic                 both_done;
    logic [7:0]           result;

    // ========================================
    // request and cache lookup
    // ========================================
    always_ff @(posedge clk) begin
        if (state == idle && in_valid) begin
            pic_q <= in_pic_no;
            ratio <= ratio_t'(in_ratio_mode);
        end
    end

    assign pic_addr = addr_w'(dram_base + pic_q * pic_bytes);
    assign hit      = rec_valid[pic_q] && (ratio == unity);
    assign result   = sum[result_shift +: 8];

    // miss leaves lookup with a start pulse, arvalid follows next edge
    assign start = (state == lookup) && !hit;
    assign clear = start;

    assign both_done = (wr_seen | wr_done) & (sum_seen | sum_done);

    // ========================================
    // FSM
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            idle:    if (in_valid) state_nxt = lookup;
            lookup:  state_nxt = hit ? dout : run;
            run:     if (both_done) state_nxt = drain;
            drain:   state_nxt = dout;
            dout:    state_nxt = idle;
            default: state_nxt = idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            state <= state_nxt;
        end
    end

    // completion pulses may arrive in either order
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_seen  <= 1'b0;
            sum_seen <= 1'b0;
        end else if (start) begin
            wr_seen  <= 1'b0;
            sum_seen <= 1'b0;
        end else begin
            if (wr_done) begin
                wr_seen <= 1'b1;
            end
            if (sum_done) begin
                sum_seen <= 1'b1;
            end
        end
    end

    // ========================================
    // result cache
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rec_valid <= '0;
        end else if (state == drain) begin
            rec_valid[pic_q] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (state == drain) begin
            rec_data[pic_q] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= (state_nxt == dout);
            if (state == lookup && hit) begin
                out_data <= rec_data[pic_q];
            end else if (state == drain) begin
                out_data <= result;
            end else begin
                out_data <= '0;
            end
        end
    end

endmodule

// ==== isp_pkg.sv ====
package isp_pkg;

    // ========================================
    // picture geometry
    // ========================================
    localparam int pic_bytes    = 3072;
    localparam int beat_bytes   = 16;
    localparam int burst_beats  = 192;
    localparam int plane_beats  = 64;
    localparam int pic_w        = 4;
    localparam int pic_count    = 16;

    // ========================================
    // bus and exposure widths
    // ========================================
    localparam logic [31:0] dram_base = 32'h0001_0000;
    localparam int data_w       = 128;
    localparam int addr_w       = 32;
    localparam int sum_w        = 18;
    localparam int result_shift = 10;
    localparam int tree_depth   = 4;

    typedef enum logic [2:0] {
        idle,
        lookup,
        run,
        drain,
        dout
    } isp_state_t;

    typedef enum logic [1:0] {
        quarter,
        half,
        unity,
        double
    } ratio_t;

    // per-byte brightness ratio, double saturates
    function automatic logic [7:0] scale_byte(input logic [7:0] b, input ratio_t r);
        case (r)
            quarter: return b >> 2;
            half:    return b >> 1;
            double:  return b[7] ? 8'hff : {b[6:0], 1'b0};
            default: return b;
        endcase
    endfunction

endpackage

// ==== isp_top.sv ====
module isp_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic [isp_pkg::pic_w-1:0]    in_pic_no,
    input  logic [1:0]                   in_ratio_mode,
    output logic                         out_valid,
    output logic [7:0]                   out_data,
    // read channels
    output logic [isp_pkg::addr_w-1:0]   araddr,
    output logic [7:0]                   arlen,
    output logic                         arvalid,
    input  logic                         arready,
    input  logic [isp_pkg::data_w-1:0]   rdata,
    input  logic                         rlast,
    input  logic                         rvalid,
    output logic                         rready,
    // write channels
    output logic [isp_pkg::addr_w-1:0]   awaddr,
    output logic [7:0]                   awlen,
    output logic                         awvalid,
    input  logic                         awready,
    output logic [isp_pkg::data_w-1:0]   wdata,
    output logic                         wlast,
    output logic                         wvalid,
    input  logic                         wready,
    input  logic                         bvalid
);
    import isp_pkg::*;

    logic              start;
    logic              clear;
    logic [addr_w-1:0] pic_addr;
    ratio_t            ratio;
    logic              wr_done;
    logic              sum_done;
    logic [sum_w-1:0]  sum;

    // beat stream from the read master
    logic              beat_valid;
    logic              beat_ready;
    logic [data_w-1:0] beat_data;
    logic [1:0]        beat_plane;
    logic              beat_last;

    isp_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pic_no     (in_pic_no),
        .in_ratio_mode (in_ratio_mode),
        .wr_done       (wr_done),
        .sum_done      (sum_done),
        .sum           (sum),
        .start         (start),
        .clear         (clear),
        .pic_addr      (pic_addr),
        .ratio         (ratio),
        .out_valid     (out_valid),
        .out_data      (out_data)
    );

    axi_read_master u_rd (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .pic_addr   (pic_addr),
        .arready    (arready),
        .rdata      (rdata),
        .rlast      (rlast),
        .rvalid     (rvalid),
        .beat_ready (beat_ready),
        .araddr     (araddr),
        .arlen      (arlen),
        .arvalid    (arvalid),
        .rready     (rready),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_plane (beat_plane),
        .beat_last  (beat_last)
    );

    axi_write_back u_wr (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .pic_addr   (pic_addr),
        .ratio      (ratio),
        .beat_valid (beat_valid),
        .beat_data  (beat_data),
        .beat_last  (beat_last),
        .awready    (awready),
        .wready     (wready),
        .bvalid     (bvalid),
        .beat_ready (beat_ready),
        .awaddr     (awaddr),
        .awlen      (awlen),
        .awvalid    (awvalid),
        .wdata      (wdata),
        .wlast      (wlast),
        .wvalid     (wvalid),
        .wr_done    (wr_done)
    );

    exposure_accum u_acc (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .ratio      (ratio),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat_data  (beat_data),
        .beat_plane (beat_plane),
        .beat_last  (beat_last),
        .sum_done   (sum_done),
        .sum        (sum)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -j 0 --top-module tb_isp -f build.f; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_isp)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
exit 1

// ==== tb_isp.sv ====
module tb_isp;
    import isp_pkg::*;

    localparam int n_reqs      = 14;
    localparam int result_wait = 8000;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    logic [pic_w-1:0]  in_pic_no;
    logic [1:0]        in_ratio_mode;
    logic              exp_hit;
    logic              out_valid;
    logic [7:0]        out_data;
    logic [addr_w-1:0] araddr;
    logic [7:0]        arlen;
    logic              arvalid;
    logic              arready;
    logic [data_w-1:0] rdata;
    logic              rlast;
    logic              rvalid;
    logic              rready;
    logic [addr_w-1:0] awaddr;
    logic [7:0]        awlen;
    logic              awvalid;
    logic              awready;
    logic [data_w-1:0] wdata;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    int                check_errors;
    int                timeouts;

    // requests as picture, ratio mode and expected cache hit
    logic [pic_w-1:0] tbl_pic [n_reqs] = '{
        4'd3, 4'd3, 4'd5, 4'd5, 4'd7, 4'd12, 4'd12,
        4'd14, 4'd3, 4'd3, 4'd7, 4'd0, 4'd14, 4'd15
    };
    logic [1:0] tbl_ratio [n_reqs] = '{
        2'd2, 2'd2, 2'd0, 2'd2, 2'd1, 2'd3, 2'd2,
        2'd3, 2'd3, 2'd2, 2'd2, 2'd2, 2'd2, 2'd1
    };
    logic tbl_hit [n_reqs] = '{
        1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1,
        1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0
    };

    isp_top u_dut (.*);

    dram_model u_dram (.*);

    isp_checker u_chk (
        .*,
        .errors (check_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // one-cycle request pulse after a rising edge
    task automatic send_request(input int k);
        in_valid      <= 1'b1;
        in_pic_no     <= tbl_pic[k];
        in_ratio_mode <= tbl_ratio[k];
        exp_hit       <= tbl_hit[k];
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_result(input int k);
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid && n < result_wait) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            timeouts++;
            $display("timeout at %0t: no result for request %0d (picture %0d) in %0d cycles",
                     $time, k, tbl_pic[k], result_wait);
        end
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        rst_n         <= 1'b0;
        in_valid      <= 1'b0;
        in_pic_no     <= '0;
        in_ratio_mode <= '0;
        exp_hit       <= 1'b0;
        timeouts = 0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        for (int k = 0; k < n_reqs && timeouts == 0; k++) begin
            send_request(k);
            wait_result(k);
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("run complete: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
